/* rtl/neuron_core_params.svh */
`ifndef NEURON_CORE_PARAMS_SVH
`define NEURON_CORE_PARAMS_SVH

// row geometry
`define NC_LANES       16
`define NC_ROW_AW      8   // 256 rows

// neuron state widths
`define NC_POT_W       20
`define NC_WEIGHT_W    16
`define NC_REF_W       3

// dynamics
`define NC_REF_CYCLES  3   // leak steps a fired neuron stays silent
`define NC_LEAK        16  // subtracted per leak step

// one threshold per group, group is the top bits of the row
`define NC_THR_GROUPS  4

`endif

/* rtl/neuron_state_pkg.sv */
`include "neuron_core_params.svh"
`default_nettype none

package neuron_state_pkg;

  // one stored neuron, 25 bits
  typedef struct packed {
    logic                 out_neuron;  // spike goes to the output spikes
    logic                 leak_en;
    logic [`NC_REF_W-1:0] ref_cnt;     // refractory steps left
    logic [`NC_POT_W-1:0] potential;   // unsigned membrane potential
  } neuron_state_t;

  // one memory row, all lanes side by side
  typedef struct packed {
    neuron_state_t [`NC_LANES-1:0] lane;
  } state_row_t;

endpackage

`default_nettype wire

/* rtl/core_ctrl_pkg.sv */
`include "neuron_core_params.svh"
`default_nettype none

package core_ctrl_pkg;

  import neuron_state_pkg::*;

  localparam int unsigned LANE_AW = $clog2(`NC_LANES);
  localparam int unsigned GRP_W   = $clog2(`NC_THR_GROUPS);

  typedef enum logic {
    STEP_SYN  = 1'b0,  // integrate weights
    STEP_LEAK = 1'b1   // time reference
  } step_kind_e;

  typedef struct packed {
    step_kind_e            kind;
    logic [`NC_ROW_AW-1:0] row;
  } step_cmd_t;

  typedef struct packed {
    logic [`NC_LANES-1:0][`NC_WEIGHT_W-1:0] weight;  // magnitude per lane
    logic [`NC_LANES-1:0]                   inhibit; // 1 subtracts
  } syn_in_t;

  typedef struct packed {
    logic [`NC_ROW_AW-1:0] row;
    logic [LANE_AW-1:0]    lane;
    neuron_state_t         state;
  } prog_cmd_t;

  typedef struct packed {
    logic [GRP_W-1:0]     group;
    logic [`NC_POT_W-1:0] threshold;
  } thr_prog_t;

  typedef struct packed {
    logic [`NC_LANES-1:0] hidden;
    logic [`NC_LANES-1:0] out;
  } spike_out_t;

endpackage

`default_nettype wire

/* rtl/lif_neuron.sv */
`timescale 1ns/1ps
`include "neuron_core_params.svh"
`default_nettype none

module lif_neuron
  import neuron_state_pkg::*, core_ctrl_pkg::*;
(
  input  step_kind_e              kind,
  input  neuron_state_t           state,
  input  logic [`NC_WEIGHT_W-1:0] weight,
  input  logic                    inhibit,
  input  logic [`NC_POT_W-1:0]    threshold,
  output neuron_state_t           state_next,
  output logic                    spike
);

  localparam int unsigned PW = `NC_POT_W;
  localparam logic [PW-1:0] POT_MAX = '1;
  localparam logic [PW-1:0] LEAK_AMT = `NC_LEAK;
  localparam logic [`NC_REF_W-1:0] REF_RELOAD = `NC_REF_CYCLES;

  logic [PW:0]   w_ext;    // one guard bit for over/underflow
  logic [PW:0]   pot_add;
  logic [PW:0]   pot_sub;
  logic [PW-1:0] pot_syn;  // clamped synaptic result
  logic [PW-1:0] pot_leak;

  assign w_ext   = {{(PW + 1 - `NC_WEIGHT_W){1'b0}}, weight};
  assign pot_add = {1'b0, state.potential} + w_ext;
  assign pot_sub = {1'b0, state.potential} - w_ext;

  always_comb begin
    if (inhibit) begin
      pot_syn = pot_sub[PW] ? '0 : pot_sub[PW-1:0];       // borrow means below zero
    end else begin
      pot_syn = pot_add[PW] ? POT_MAX : pot_add[PW-1:0];  // carry saturates
    end
  end

  assign pot_leak = (state.potential > LEAK_AMT) ? state.potential - LEAK_AMT : '0;

  always_comb begin
    state_next = state;
    spike      = 1'b0;
    if (kind == STEP_LEAK) begin
      if (state.ref_cnt != '0) begin
        state_next.ref_cnt = state.ref_cnt - 1'b1;
      end
      if (state.leak_en) begin
        state_next.potential = pot_leak;
      end
    end else if (state.ref_cnt == '0) begin
      // refractory lanes ignore input entirely
      if (pot_syn >= threshold) begin
        spike                = 1'b1;
        state_next.potential = '0;          // reset on fire
        state_next.ref_cnt   = REF_RELOAD;
      end else begin
        state_next.potential = pot_syn;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/neuron_state_mem.sv */
`timescale 1ns/1ps
`include "neuron_core_params.svh"
`default_nettype none

module neuron_state_mem
  import neuron_state_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rd_en,
  input  logic [`NC_ROW_AW-1:0] rd_row,
  output state_row_t            rd_data,
  input  logic [`NC_LANES-1:0]  wr_lanes,
  input  logic [`NC_ROW_AW-1:0] wr_row,
  input  state_row_t            wr_data
);

  localparam int unsigned NROWS = 1 << `NC_ROW_AW;

  state_row_t mem [NROWS];

  // write port, one enable per lane
  always_ff @(posedge CLK) begin
    for (int l = 0; l < `NC_LANES; l++) begin
      if (wr_lanes[l]) begin
        mem[wr_row].lane[l] <= wr_data.lane[l];
      end
    end
  end

  // read port, write-first per lane on a row collision
  always_ff @(posedge CLK) begin
    if (rd_en) begin
      for (int l = 0; l < `NC_LANES; l++) begin
        if (wr_lanes[l] && (wr_row == rd_row)) begin
          rd_data.lane[l] <= wr_data.lane[l];
        end else begin
          rd_data.lane[l] <= mem[rd_row].lane[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/threshold_regs.sv */
`timescale 1ns/1ps
`include "neuron_core_params.svh"
`default_nettype none

module threshold_regs
  import core_ctrl_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RSTN_syncn,
  input  logic                 thr_strobe,
  input  thr_prog_t            thr,
  input  logic [GRP_W-1:0]     group,
  output logic [`NC_POT_W-1:0] threshold
);

  logic [`NC_POT_W-1:0] thr_q [`NC_THR_GROUPS];

  always_ff @(posedge CLK or negedge RSTN_syncn) begin
    if (!RSTN_syncn) begin
      for (int g = 0; g < `NC_THR_GROUPS; g++) begin
        thr_q[g] <= '1;  // max, nothing fires until programmed
      end
    end else if (thr_strobe) begin
      thr_q[thr.group] <= thr.threshold;
    end
  end

  assign threshold = thr_q[group];

endmodule

`default_nettype wire

/* rtl/neuron_core.sv */
`timescale 1ns/1ps
`include "neuron_core_params.svh"
`default_nettype none

module neuron_core
  import neuron_state_pkg::*, core_ctrl_pkg::*;
(
  input  logic       CLK,
  input  logic       RSTN_syncn,
  input  logic       step_strobe,
  input  step_cmd_t  step,
  input  syn_in_t    syn,
  input  logic       prog_strobe,
  input  prog_cmd_t  prog,
  input  logic       thr_strobe,
  input  thr_prog_t  thr,
  output logic       spike_valid,
  output spike_out_t spikes
);

  // fetch stage
  logic       fetch_valid;
  step_cmd_t  fetch_cmd;
  syn_in_t    fetch_syn;
  state_row_t rd_row_data;
  state_row_t cur_row;
  state_row_t next_row;

  logic [`NC_LANES-1:0] lane_spike;
  logic [`NC_POT_W-1:0] threshold;
  spike_out_t           spikes_d;

  // update stage, also the write-back source
  logic                  upd_valid;
  logic [`NC_ROW_AW-1:0] upd_row;
  state_row_t            upd_data;

  logic [`NC_LANES-1:0]  wr_lanes;
  logic [`NC_ROW_AW-1:0] wr_row;
  state_row_t            wr_data;

  neuron_state_mem u_state_mem (
    .CLK      (CLK),
    .rd_en    (step_strobe),
    .rd_row   (step.row),
    .rd_data  (rd_row_data),
    .wr_lanes (wr_lanes),
    .wr_row   (wr_row),
    .wr_data  (wr_data)
  );

  always_ff @(posedge CLK or negedge RSTN_syncn) begin
    if (!RSTN_syncn) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= step_strobe;
    end
  end

  always_ff @(posedge CLK) begin
    if (step_strobe) begin
      fetch_cmd <= step;
      fetch_syn <= syn;
    end
  end

  // the previous step to this row is still in the update stage and has not
  // reached memory yet, so its row replaces the stale read data
  assign cur_row = (upd_valid && (upd_row == fetch_cmd.row)) ? upd_data : rd_row_data;

  threshold_regs u_thresholds (
    .CLK        (CLK),
    .RSTN_syncn (RSTN_syncn),
    .thr_strobe (thr_strobe),
    .thr        (thr),
    .group      (fetch_cmd.row[`NC_ROW_AW-1 -: GRP_W]),  // top row bits
    .threshold  (threshold)
  );

  for (genvar i = 0; i < `NC_LANES; i++) begin : g_lane
    lif_neuron u_lif (
      .kind       (fetch_cmd.kind),
      .state      (cur_row.lane[i]),
      .weight     (fetch_syn.weight[i]),
      .inhibit    (fetch_syn.inhibit[i]),
      .threshold  (threshold),
      .state_next (next_row.lane[i]),
      .spike      (lane_spike[i])
    );

    // route by the stored flag
    assign spikes_d.hidden[i] = fetch_valid & lane_spike[i] & ~cur_row.lane[i].out_neuron;
    assign spikes_d.out[i]    = fetch_valid & lane_spike[i] & cur_row.lane[i].out_neuron;
  end

  always_ff @(posedge CLK or negedge RSTN_syncn) begin
    if (!RSTN_syncn) begin
      upd_valid   <= 1'b0;
      spike_valid <= 1'b0;
      spikes      <= '0;
    end else begin
      upd_valid   <= fetch_valid;
      spike_valid <= fetch_valid;
      spikes      <= spikes_d;
    end
  end

  always_ff @(posedge CLK) begin
    if (fetch_valid) begin
      upd_row  <= fetch_cmd.row;
      upd_data <= next_row;
    end
  end

  // write-back wins over a program write
  always_comb begin
    wr_lanes = '0;
    wr_row   = upd_row;
    wr_data  = upd_data;
    if (upd_valid) begin
      wr_lanes = '1;
    end else if (prog_strobe) begin
      wr_lanes[prog.lane] = 1'b1;
      wr_row              = prog.row;
      wr_data.lane        = {`NC_LANES{prog.state}};  // only the enabled lane lands
    end
  end

endmodule

`default_nettype wire

/* tests/neuron_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module neuron_core_props
  import core_ctrl_pkg::*;
(
  input logic       CLK,
  input logic       RSTN_syncn,
  input logic       step_strobe,
  input logic       spike_valid,
  input spike_out_t spikes
);

  int unsigned assert_fails = 0;

  // fixed two-cycle latency, and no pulse without a step
  a_latency: assert property (
    @(posedge CLK) disable iff (!RSTN_syncn) spike_valid == $past(step_strobe, 2)
  ) else begin
    assert_fails++;
    $error("spike_valid does not follow step_strobe by two cycles");
  end

  a_quiet: assert property (
    @(posedge CLK) disable iff (!RSTN_syncn) !spike_valid |-> spikes == '0
  ) else begin
    assert_fails++;
    $error("spikes nonzero while spike_valid is low");
  end

  a_routed_once: assert property (
    @(posedge CLK) disable iff (!RSTN_syncn) (spikes.hidden & spikes.out) == '0
  ) else begin
    assert_fails++;
    $error("a lane spiked on both hidden and output spikes");
  end

endmodule

`default_nettype wire

/* tests/neuron_core_tb.sv */
`timescale 1ns/1ps
`include "neuron_core_params.svh"
`default_nettype none

module neuron_core_tb
  import neuron_state_pkg::*, core_ctrl_pkg::*;
();

  localparam int MAX_CYCLES = 4000;  // directed sequence runs a few hundred cycles
  localparam int POT_MAX    = (1 << `NC_POT_W) - 1;

  logic       CLK;
  logic       RSTN_syncn;
  logic       step_strobe;
  step_cmd_t  step;
  syn_in_t    syn;
  logic       prog_strobe;
  prog_cmd_t  prog;
  logic       thr_strobe;
  thr_prog_t  thr;
  logic       spike_valid;
  spike_out_t spikes;

  state_row_t  model [1 << `NC_ROW_AW];  // reference copy of the state memory
  int          thr_model [`NC_THR_GROUPS];
  spike_out_t  exp_q [$];                // one entry per step in flight
  spike_out_t  exp_spikes;
  logic [31:0] rng = 32'hef7ce512;
  string       test_name = "reset";
  int          errors;
  int          cycles;

  neuron_core neuron_core_i (.*);

  bind neuron_core neuron_core_props u_props (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) cycles <= cycles + 1;

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout after %0d cycles, a step never retired", cycles);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // every spike_valid pulse retires the oldest step
  always @(negedge CLK) begin
    if (spike_valid && exp_q.size() == 0) begin
      errors++;
      $display("%s: spike_valid pulsed with no step in flight", test_name);
    end else if (spike_valid) begin
      exp_spikes = exp_q.pop_front();
      check(test_name, exp_spikes, spikes);
    end
  end

  // reference update of one row by the LIF rule
  task automatic model_step(input step_kind_e kind, input logic [`NC_ROW_AW-1:0] row,
                            input syn_in_t s, output spike_out_t sp);
    neuron_state_t st;
    int            p;
    int            w;
    int            limit;
    limit = thr_model[row >> (`NC_ROW_AW - GRP_W)];
    sp    = '0;
    for (int l = 0; l < `NC_LANES; l++) begin
      st = model[row].lane[l];
      p  = st.potential;
      w  = s.weight[l];
      if (kind == STEP_LEAK) begin
        if (st.ref_cnt != 0) begin
          st.ref_cnt = st.ref_cnt - 1;
        end
        if (st.leak_en) begin
          p = (p > `NC_LEAK) ? p - `NC_LEAK : 0;
        end
      end else if (st.ref_cnt == 0) begin
        p = s.inhibit[l] ? p - w : p + w;
        p = (p < 0) ? 0 : (p > POT_MAX) ? POT_MAX : p;
        if (p >= limit) begin
          p          = 0;
          st.ref_cnt = `NC_REF_CYCLES;
          sp.out[l]    = st.out_neuron;
          sp.hidden[l] = !st.out_neuron;
        end
      end
      st.potential       = p;
      model[row].lane[l] = st;
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK);
    #1;
    step_strobe = 1'b0;
    prog_strobe = 1'b0;
    thr_strobe  = 1'b0;
  endtask

  task automatic do_step(input step_kind_e kind, input logic [`NC_ROW_AW-1:0] row,
                         input syn_in_t s);
    spike_out_t sp;
    model_step(kind, row, s, sp);
    exp_q.push_back(sp);
    next_cycle();
    step_strobe = 1'b1;
    step.kind   = kind;
    step.row    = row;
    syn         = s;
  endtask

  task automatic prog_row(input logic [`NC_ROW_AW-1:0] row, input int pot,
                          input logic [15:0] leak_mask, input logic [15:0] out_mask);
    neuron_state_t st;
    for (int l = 0; l < `NC_LANES; l++) begin
      st = '{out_neuron: out_mask[l], leak_en: leak_mask[l], ref_cnt: '0, potential: pot};
      model[row].lane[l] = st;
      next_cycle();
      prog_strobe = 1'b1;
      prog.row    = row;
      prog.lane   = l;
      prog.state  = st;
    end
  endtask

  task automatic set_thr(input int group, input int value);
    thr_model[group] = value;
    next_cycle();
    thr_strobe    = 1'b1;
    thr.group     = group;
    thr.threshold = value;
  endtask

  task automatic drain();
    next_cycle();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
    @(posedge CLK);  // last write-back lands
  endtask

  function automatic syn_in_t rand_syn(input int max_w, input int inh_pct);
    syn_in_t s;
    for (int l = 0; l < `NC_LANES; l++) begin
      s.weight[l]  = next_rand() % max_w;
      s.inhibit[l] = (next_rand() % 100) < inh_pct;
    end
    return s;
  endfunction

  // hit lanes land exactly on threshold and the rest one below
  task automatic probe_row(input logic [`NC_ROW_AW-1:0] row, input logic [15:0] hit);
    syn_in_t s;
    int      d;
    s = '0;
    for (int l = 0; l < `NC_LANES; l++) begin
      d = thr_model[row >> (`NC_ROW_AW - GRP_W)] - int'(model[row].lane[l].potential);
      s.weight[l] = hit[l] ? d : d - 1;
    end
    do_step(STEP_SYN, row, s);
  endtask

  task automatic integrate_below_threshold();
    test_name = "integration";
    set_thr(0, 32768);
    prog_row(8'd5, 1000, 16'h0000, 16'h0000);
    for (int i = 0; i < 8; i++) begin
      do_step(STEP_SYN, 8'd5, rand_syn(1024, 30));
    end
    probe_row(8'd5, 16'h5a3c);
    drain();
  endtask

  task automatic fire_and_refractory();
    syn_in_t big;
    syn_in_t mix;
    test_name = "fire_refractory";
    set_thr(0, 2000);
    prog_row(8'd6, 0, 16'h0000, 16'h0f0f);
    big = '0;
    mix = '0;
    for (int l = 0; l < `NC_LANES; l++) begin
      big.weight[l] = 2500;
      mix.weight[l] = (l < 8) ? 2500 : 100;
    end
    do_step(STEP_SYN, 8'd6, mix);   // low half fires
    do_step(STEP_SYN, 8'd6, big);   // high half fires while low half is silent
    do_step(STEP_SYN, 8'd6, big);   // everything refractory
    do_step(STEP_LEAK, 8'd6, '0);
    do_step(STEP_LEAK, 8'd6, '0);
    do_step(STEP_SYN, 8'd6, big);   // one count left so still ignored
    do_step(STEP_LEAK, 8'd6, '0);
    do_step(STEP_SYN, 8'd6, big);   // integrating again
    drain();
  endtask

  task automatic leak_to_zero();
    test_name = "leak";
    set_thr(0, 2000);
    prog_row(8'd7, 40, 16'h5555, 16'h0000);
    repeat (4) begin
      do_step(STEP_LEAK, 8'd7, '0);  // 40 24 8 0 0 on leaking lanes
    end
    probe_row(8'd7, 16'h00ff);
    drain();
  endtask

  task automatic route_by_group();
    logic [`NC_ROW_AW-1:0] rows [4] = '{8'd10, 8'd70, 8'd140, 8'd200};
    int                    limits [4] = '{2000, 1000, 3000, 500};
    syn_in_t               ramp;
    test_name = "routing";
    ramp      = '0;
    for (int l = 0; l < `NC_LANES; l++) begin
      ramp.weight[l] = l * 250;
    end
    for (int g = 0; g < 4; g++) begin
      set_thr(g, limits[g]);
      prog_row(rows[g], 0, 16'h0000, 16'ha5a5 ^ (16'h1111 << g));
    end
    for (int g = 0; g < 4; g++) begin
      do_step(STEP_SYN, rows[g], ramp);
    end
    drain();
  endtask

  task automatic back_to_back_bypass();
    logic [`NC_ROW_AW-1:0] row;
    step_kind_e            kind;
    test_name = "bypass";
    set_thr(0, 2000);
    prog_row(8'd20, 0, 16'h0f0f, 16'h3300);
    prog_row(8'd21, 500, 16'hf0f0, 16'h00cc);
    for (int i = 0; i < 40; i++) begin
      row  = (next_rand() % 3 == 0) ? 8'd21 : 8'd20;  // mostly the same row
      kind = (next_rand() % 4 == 0) ? STEP_LEAK : STEP_SYN;
      do_step(kind, row, rand_syn(700, 25));
    end
    probe_row(8'd20, 16'hff00);
    probe_row(8'd21, 16'h0ff0);
    drain();
  endtask

  initial begin
    RSTN_syncn  = 1'b0;
    step_strobe = 1'b0;
    step        = '0;
    syn         = '0;
    prog_strobe = 1'b0;
    prog        = '0;
    thr_strobe  = 1'b0;
    thr         = '0;
    for (int g = 0; g < `NC_THR_GROUPS; g++) begin
      thr_model[g] = POT_MAX;  // reset value of every threshold
    end
    repeat (5) @(posedge CLK);
    #1 RSTN_syncn = 1'b1;
    integrate_below_threshold();
    fire_and_refractory();
    leak_to_zero();
    route_by_group();
    back_to_back_bypass();
    $display("errors: %0d check, %0d assertion", errors, neuron_core_i.u_props.assert_fails);
    if (errors == 0 && neuron_core_i.u_props.assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/neuron_state_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/lif_neuron.sv
rtl/neuron_state_mem.sv
rtl/threshold_regs.sv
rtl/neuron_core.sv
tests/neuron_core_props.sv
tests/neuron_core_tb.sv

/* Bender.yml */
package:
  name: neuron_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/neuron_state_pkg.sv
      - rtl/core_ctrl_pkg.sv
      - rtl/lif_neuron.sv
      - rtl/neuron_state_mem.sv
      - rtl/threshold_regs.sv
      - rtl/neuron_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/neuron_core_props.sv
      - tests/neuron_core_tb.sv
